// File: logic/cpu_pkg.sv
// ======================================
// cpu package
// shared widths, opcode and ALU enums, the
// instruction layout and the pipeline structs
// ======================================

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 17;

    typedef enum logic [4:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_BNE   = 5'b00010,
        OP_ADDI  = 5'b00101,
        OP_BLT   = 5'b00110,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'b00000,
        ALU_SUB = 5'b00001,
        ALU_AND = 5'b00010,
        ALU_OR  = 5'b00011,
        ALU_SLL = 5'b00100,
        ALU_SRA = 5'b00101
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00,                   // value read in decode
        FWD_MEM = 2'b01,                   // X/M result
        FWD_WB  = 2'b10                    // writeback value
    } fwd_sel_e;

    // R-type view; I-type imm and J target overlay the low bits
    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [4:0]            shamt;
        alu_op_e               alu_op;
        logic [1:0]            pad;
    } insn_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] insn;             // all zero is a bubble
    } fd_reg_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        opcode_e               opcode;
        alu_op_e               alu_op;
        logic [4:0]            shamt;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;         // second source register actually read
        logic [IMM_W-1:0]      imm;
        logic [XLEN-1:0]       opa;
        logic [XLEN-1:0]       opb;
        logic                  wr_en;
    } dx_reg_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wr_en;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_data;
    } xm_reg_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wr_en;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       load_data;
    } mw_reg_t;

    typedef struct packed {
        logic     stall_f;                 // hold PC and F/D
        logic     flush_d;                 // bubble into F/D
        logic     flush_x;                 // bubble into D/X
        fwd_sel_e fwd_a;
        fwd_sel_e fwd_b;
    } hz_ctrl_t;

endpackage

// File: logic/reg_file.sv
// ======================================
// register file
// 32 x 32, two read ports, one write port,
// r0 reads zero, write seen by same-cycle read
// ======================================
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] ra_i,
    input  logic [REG_ADDR_W-1:0] rb_i,
    output logic [XLEN-1:0]       da_o,
    output logic [XLEN-1:0]       db_o,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] wa_i,
    input  logic [XLEN-1:0]       wd_i
);

    logic [XLEN-1:0] regs [1:(1<<REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    function automatic logic [XLEN-1:0] rd_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (we_i && wa_i == addr) begin
            val = wd_i;                           // write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        da_o = rd_port(ra_i);
        db_o = rd_port(rb_i);
    end

    a_no_wr_in_reset: assert property (@(posedge clk) !rst_n_i |-> !we_i)
        else $error("register write during reset");

endmodule

// File: logic/hazard_ctrl.sv
// ======================================
// hazard control
// load-use stall, branch flush and the
// forwarding selects for execute
// ======================================
`timescale 1ns/100ps

module hazard_ctrl import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] dec_rs_i,
    input  logic [REG_ADDR_W-1:0] dec_rt_i,
    input  dx_reg_t               dx_i,
    input  xm_reg_t               xm_i,
    input  mw_reg_t               mw_i,
    input  logic                  branch_taken_i,
    output hz_ctrl_t              hz_o,
    output logic                  redirect_o
);

    logic load_use;

    // youngest producer wins
    function automatic fwd_sel_e pick_src(
        input logic [REG_ADDR_W-1:0] src,
        input logic                  m_we,
        input logic [REG_ADDR_W-1:0] m_rd,
        input logic                  w_we,
        input logic [REG_ADDR_W-1:0] w_rd
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (m_we && m_rd == src) begin
            sel = FWD_MEM;
        end else if (w_we && w_rd == src) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    // wr_en already excludes r0, so no zero compare needed
    assign load_use = (dx_i.opcode == OP_LW) && dx_i.wr_en &&
                      ((dx_i.rd == dec_rs_i) || (dx_i.rd == dec_rt_i));

    always_comb begin
        hz_o.stall_f = load_use;
        hz_o.flush_d = branch_taken_i;                // wrong-path fetch
        hz_o.flush_x = branch_taken_i | load_use;     // bubble for both cases
        hz_o.fwd_a   = pick_src(dx_i.rs, xm_i.wr_en, xm_i.rd, mw_i.wr_en, mw_i.rd);
        hz_o.fwd_b   = pick_src(dx_i.rt, xm_i.wr_en, xm_i.rd, mw_i.wr_en, mw_i.rd);
    end

    assign redirect_o = branch_taken_i;

    // the bubble behind a stalled lw can never trigger another stall
    a_stall_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        hz_o.stall_f |=> !hz_o.stall_f)
        else $error("load-use stall held for two cycles");

    a_fwd_a_no_r0: assert property (@(posedge clk) disable iff (!rst_n_i)
        (hz_o.fwd_a != FWD_REG) |-> (dx_i.rs != '0))
        else $error("operand a forwarded from r0");

    a_fwd_b_no_r0: assert property (@(posedge clk) disable iff (!rst_n_i)
        (hz_o.fwd_b != FWD_REG) |-> (dx_i.rt != '0))
        else $error("operand b forwarded from r0");

endmodule

// File: logic/fetch_stage.sv
// ======================================
// fetch stage
// program counter, imem address and the
// F/D pipeline register
// ======================================
`timescale 1ns/100ps

module fetch_stage import cpu_pkg::*; #(
    parameter int PC_W = 8
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  hz_ctrl_t        hz_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] branch_target_i,
    output logic [PC_W-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_data_i,
    output fd_reg_t         fd_o
);

    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_next;

    always_comb begin
        if (redirect_i) begin
            pc_next = PC_W'(branch_target_i);         // redirect beats stall
        end else if (hz_i.stall_f) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + PC_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign imem_addr_o = pc_q;                        // combinational imem read

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fd_o <= '0;
        end else if (hz_i.flush_d) begin
            fd_o <= '0;                               // bubble
        end else if (!hz_i.stall_f) begin
            fd_o.pc   <= XLEN'(pc_q);
            fd_o.insn <= imem_data_i;
        end
    end

endmodule

// File: logic/decode_stage.sv
// ======================================
// decode stage
// field split, register read addresses,
// write flag and the D/X register
// ======================================
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  fd_reg_t               fd_i,
    input  hz_ctrl_t              hz_i,
    output logic [REG_ADDR_W-1:0] rf_ra_o,
    output logic [REG_ADDR_W-1:0] rf_rb_o,
    input  logic [XLEN-1:0]       rf_da_i,
    input  logic [XLEN-1:0]       rf_db_i,
    output logic [REG_ADDR_W-1:0] dec_rs_o,
    output logic [REG_ADDR_W-1:0] dec_rt_o,
    output dx_reg_t               dx_o
);

    insn_t   ins;
    logic    wr_en;
    dx_reg_t dx_next;

    assign ins = insn_t'(fd_i.insn);

    always_comb begin
        rf_ra_o = ins.rs;
        rf_rb_o = '0;
        unique case (ins.opcode)
            OP_RTYPE:               rf_rb_o = ins.rt;
            OP_SW, OP_BNE, OP_BLT:  rf_rb_o = ins.rd;     // rd is a source here
            OP_J:                   rf_ra_o = '0;         // rs bits belong to target
            default:                rf_rb_o = '0;
        endcase
    end

    assign dec_rs_o = rf_ra_o;
    assign dec_rt_o = rf_rb_o;

    assign wr_en = ((ins.opcode == OP_RTYPE) || (ins.opcode == OP_ADDI) ||
                    (ins.opcode == OP_LW)) && (ins.rd != '0);

    always_comb begin
        dx_next.pc     = fd_i.pc;
        dx_next.opcode = ins.opcode;
        dx_next.alu_op = ins.alu_op;
        dx_next.shamt  = ins.shamt;
        dx_next.rd     = ins.rd;
        dx_next.rs     = ins.rs;                  // raw, j needs it for the target
        dx_next.rt     = rf_rb_o;
        dx_next.imm    = fd_i.insn[IMM_W-1:0];
        dx_next.opa    = rf_da_i;
        dx_next.opb    = rf_db_i;
        dx_next.wr_en  = wr_en;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dx_o <= '0;
        end else if (hz_i.stall_f || hz_i.flush_x) begin
            dx_o <= '0;                           // bubble
        end else begin
            dx_o <= dx_next;
        end
    end

endmodule

// File: logic/execute_stage.sv
// ======================================
// execute stage
// operand forwarding, ALU, branch compare
// and target, and the X/M register
// ======================================
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  dx_reg_t         dx_i,
    input  hz_ctrl_t        hz_i,
    input  logic [XLEN-1:0] xm_fwd_i,
    input  logic [XLEN-1:0] wb_fwd_i,
    output logic            branch_taken_o,
    output logic [XLEN-1:0] branch_target_o,
    output xm_reg_t         xm_o
);

    logic [XLEN-1:0] a_val;
    logic [XLEN-1:0] b_val;
    logic [XLEN-1:0] imm_sx;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    alu_op_e         alu_op;
    logic            use_imm;
    logic            ne;
    logic            lt;

    always_comb begin
        unique case (hz_i.fwd_a)
            FWD_MEM: a_val = xm_fwd_i;
            FWD_WB:  a_val = wb_fwd_i;
            default: a_val = dx_i.opa;
        endcase
        unique case (hz_i.fwd_b)
            FWD_MEM: b_val = xm_fwd_i;
            FWD_WB:  b_val = wb_fwd_i;
            default: b_val = dx_i.opb;
        endcase
    end

    assign imm_sx  = {{(XLEN-IMM_W){dx_i.imm[IMM_W-1]}}, dx_i.imm};
    assign use_imm = (dx_i.opcode == OP_ADDI) || (dx_i.opcode == OP_LW) ||
                     (dx_i.opcode == OP_SW);
    assign alu_b   = use_imm ? imm_sx : b_val;
    assign alu_op  = (dx_i.opcode == OP_RTYPE) ? dx_i.alu_op : ALU_ADD;

    always_comb begin
        unique case (alu_op)
            ALU_ADD: alu_res = a_val + alu_b;
            ALU_SUB: alu_res = a_val - alu_b;
            ALU_AND: alu_res = a_val & alu_b;
            ALU_OR:  alu_res = a_val | alu_b;
            ALU_SLL: alu_res = a_val << dx_i.shamt;
            ALU_SRA: alu_res = $signed(a_val) >>> dx_i.shamt;
            default: alu_res = '0;
        endcase
    end

    // branches compare rd (b side) against rs (a side)
    assign ne = (b_val != a_val);
    assign lt = ($signed(b_val) < $signed(a_val));

    assign branch_taken_o = (dx_i.opcode == OP_J) ||
                            ((dx_i.opcode == OP_BNE) && ne) ||
                            ((dx_i.opcode == OP_BLT) && lt);

    assign branch_target_o = (dx_i.opcode == OP_J) ?
                             XLEN'({dx_i.rd, dx_i.rs, dx_i.imm}) :   // 27-bit target
                             dx_i.pc + XLEN'(1) + imm_sx;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            xm_o <= '0;
        end else begin
            xm_o.opcode     <= dx_i.opcode;
            xm_o.rd         <= dx_i.rd;
            xm_o.wr_en      <= dx_i.wr_en;
            xm_o.result     <= alu_res;
            xm_o.store_data <= b_val;             // rd value for sw
        end
    end

    // the flushed slot behind a taken branch cannot branch again
    a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n_i)
        branch_taken_o |=> !branch_taken_o)
        else $error("taken branch right after a taken branch");

endmodule

// File: logic/mem_wb_stage.sv
// ======================================
// memory and writeback stage
// data memory port, M/W register and the
// writeback select
// ======================================
`timescale 1ns/100ps

module mem_wb_stage import cpu_pkg::*; #(
    parameter int DADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  xm_reg_t               xm_i,
    output logic [DADDR_W-1:0]    dmem_addr_o,
    output logic [XLEN-1:0]       dmem_wdata_o,
    output logic                  dmem_we_o,
    input  logic [XLEN-1:0]       dmem_rdata_i,
    output mw_reg_t               mw_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]       wb_data_o
);

    assign dmem_addr_o  = DADDR_W'(xm_i.result);  // word address from ALU
    assign dmem_wdata_o = xm_i.store_data;
    assign dmem_we_o    = (xm_i.opcode == OP_SW);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mw_o <= '0;
        end else begin
            mw_o.opcode    <= xm_i.opcode;
            mw_o.rd        <= xm_i.rd;
            mw_o.wr_en     <= xm_i.wr_en;
            mw_o.result    <= xm_i.result;
            mw_o.load_data <= dmem_rdata_i;
        end
    end

    assign wb_we_o   = mw_o.wr_en;
    assign wb_addr_o = mw_o.rd;
    assign wb_data_o = (mw_o.opcode == OP_LW) ? mw_o.load_data : mw_o.result;

endmodule

// File: logic/cpu_top.sv
// ======================================
// cpu top
// five-stage pipeline with register file,
// exposes instruction and data memory ports
// ======================================
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; #(
    parameter int PC_W    = 8,
    parameter int DADDR_W = 8
) (
    input  logic               clk,
    input  logic               rst_n_i,
    output logic [PC_W-1:0]    imem_addr_o,
    input  logic [XLEN-1:0]    imem_data_i,
    output logic [DADDR_W-1:0] dmem_addr_o,
    output logic [XLEN-1:0]    dmem_wdata_o,
    output logic               dmem_we_o,
    input  logic [XLEN-1:0]    dmem_rdata_i
);

    fd_reg_t               fd;
    dx_reg_t               dx;
    xm_reg_t               xm;
    mw_reg_t               mw;
    hz_ctrl_t              hz;
    logic [REG_ADDR_W-1:0] rf_ra;
    logic [REG_ADDR_W-1:0] rf_rb;
    logic [XLEN-1:0]       rf_da;
    logic [XLEN-1:0]       rf_db;
    logic [REG_ADDR_W-1:0] dec_rs;
    logic [REG_ADDR_W-1:0] dec_rt;
    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target;
    logic                  redirect;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0]       wb_data;

    fetch_stage #(.PC_W(PC_W)) u_fetch (
        .clk(clk), .rst_n_i(rst_n_i), .hz_i(hz), .redirect_i(redirect),
        .branch_target_i(branch_target), .imem_addr_o(imem_addr_o),
        .imem_data_i(imem_data_i), .fd_o(fd)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n_i(rst_n_i), .fd_i(fd), .hz_i(hz),
        .rf_ra_o(rf_ra), .rf_rb_o(rf_rb), .rf_da_i(rf_da), .rf_db_i(rf_db),
        .dec_rs_o(dec_rs), .dec_rt_o(dec_rt), .dx_o(dx)
    );

    reg_file u_rf (
        .clk(clk), .rst_n_i(rst_n_i), .ra_i(rf_ra), .rb_i(rf_rb),
        .da_o(rf_da), .db_o(rf_db), .we_i(wb_we), .wa_i(wb_addr), .wd_i(wb_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n_i(rst_n_i), .dx_i(dx), .hz_i(hz),
        .xm_fwd_i(xm.result), .wb_fwd_i(wb_data),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target), .xm_o(xm)
    );

    mem_wb_stage #(.DADDR_W(DADDR_W)) u_mem_wb (
        .clk(clk), .rst_n_i(rst_n_i), .xm_i(xm),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
        .dmem_we_o(dmem_we_o), .dmem_rdata_i(dmem_rdata_i), .mw_o(mw),
        .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    hazard_ctrl u_hazard (
        .clk(clk), .rst_n_i(rst_n_i), .dec_rs_i(dec_rs), .dec_rt_i(dec_rt),
        .dx_i(dx), .xm_i(xm), .mw_i(mw), .branch_taken_i(branch_taken),
        .hz_o(hz), .redirect_o(redirect)
    );

endmodule

// File: verif/cpu_tb_prog.svh
// ========================================
// cpu test program
// ISA encoders, the program image and the
// expected store list of the pipeline testbench
// ========================================
`ifndef CPU_TB_PROG_SVH
`define CPU_TB_PROG_SVH

localparam int PROG_LEN = 43;
localparam int HALT_PC  = 42;                  // j to itself

function automatic logic [XLEN-1:0] enc_r(alu_op_e op, int rd, int rs, int rt, int shamt);
    return {OP_RTYPE, 5'(rd), 5'(rs), 5'(rt), 5'(shamt), op, 2'b00};
endfunction

function automatic logic [XLEN-1:0] enc_i(opcode_e op, int rd, int rs, int imm);
    return {op, 5'(rd), 5'(rs), 17'(imm)};
endfunction

function automatic logic [XLEN-1:0] enc_j(int target);
    return {OP_J, 27'(target)};
endfunction

task automatic load_program();
    for (int a = 0; a < IMEM_WORDS; a++) begin
        imem[a] = enc_j(a);                    // unused words trap the PC
    end
    imem[0]  = enc_i(OP_ADDI, 1, 0, 'h1234);
    imem[1]  = enc_i(OP_ADDI, 2, 1, -'h34);    // r2 = 0x1200
    imem[2]  = enc_r(ALU_ADD, 3, 2, 1, 0);     // mem and wb forward
    imem[3]  = enc_r(ALU_SUB, 4, 1, 3, 0);
    imem[4]  = enc_r(ALU_AND, 5, 4, 3, 0);
    imem[5]  = enc_r(ALU_OR, 6, 5, 1, 0);
    imem[6]  = enc_r(ALU_SLL, 7, 6, 0, 21);
    imem[7]  = enc_r(ALU_SRA, 8, 7, 0, 8);     // negative operand
    imem[8]  = enc_i(OP_SW, 8, 0, 5);
    imem[9]  = enc_i(OP_SW, 7, 0, 4);
    imem[10] = enc_i(OP_SW, 6, 0, 3);
    imem[11] = enc_i(OP_SW, 5, 0, 2);
    imem[12] = enc_i(OP_SW, 4, 0, 1);
    imem[13] = enc_i(OP_SW, 3, 0, 0);
    imem[14] = enc_i(OP_ADDI, 0, 0, 77);       // r0 stays zero
    imem[15] = enc_i(OP_SW, 0, 0, 6);
    imem[16] = enc_i(OP_ADDI, 12, 0, 36);
    imem[17] = enc_i(OP_LW, 9, 12, -4);        // word 32
    imem[18] = enc_i(OP_ADDI, 10, 9, 5);       // load-use bubble
    imem[19] = enc_i(OP_SW, 10, 0, 7);
    imem[20] = enc_i(OP_LW, 14, 12, 2);        // word 38
    imem[21] = enc_i(OP_SW, 14, 0, 8);         // store data waits on load
    imem[22] = enc_i(OP_ADDI, 15, 0, -5);
    imem[23] = enc_i(OP_ADDI, 16, 0, 3);
    imem[24] = enc_i(OP_BNE, 15, 16, 2);       // taken to 27
    imem[25] = enc_i(OP_SW, 1, 0, POISON_ADDR);
    imem[26] = enc_i(OP_SW, 1, 0, POISON_ADDR);
    imem[27] = enc_i(OP_SW, 15, 0, 9);
    imem[28] = enc_i(OP_BLT, 15, 16, 2);       // -5 < 3, taken to 31
    imem[29] = enc_i(OP_SW, 1, 0, POISON_ADDR);
    imem[30] = enc_i(OP_SW, 1, 0, POISON_ADDR);
    imem[31] = enc_i(OP_SW, 16, 0, 10);
    imem[32] = enc_j(35);
    imem[33] = enc_i(OP_SW, 1, 0, POISON_ADDR);
    imem[34] = enc_i(OP_SW, 1, 0, POISON_ADDR);
    imem[35] = enc_i(OP_SW, 2, 0, 11);
    imem[36] = enc_i(OP_ADDI, 18, 16, 0);
    imem[37] = enc_i(OP_BNE, 18, 16, 2);       // equal, falls through
    imem[38] = enc_i(OP_SW, 18, 0, 12);
    imem[39] = enc_i(OP_BLT, 16, 15, 2);       // 3 < -5 false when signed
    imem[40] = enc_i(OP_SW, 15, 0, 13);
    imem[41] = enc_i(OP_SW, 10, 0, 63);        // end marker
    imem[42] = enc_j(HALT_PC);
endtask

task automatic build_expected();
    add_store("alu_sra", 5, 32'hffc6_8000);     // 0xc6800000 >>> 8
    add_store("alu_sll", 4, 32'hc680_0000);     // 0x3634 << 21
    add_store("alu_or", 3, 32'h0000_3634);      // 0x2400 | 0x1234
    add_store("alu_and", 2, 32'h0000_2400);     // 0xffffee00 & 0x2434
    add_store("alu_sub", 1, 32'hffff_ee00);     // 0x1234 - 0x2434
    add_store("alu_add", 0, 32'h0000_2434);     // 0x1200 + 0x1234
    add_store("r0_write", 6, 32'h0000_0000);
    add_store("load_use_addi", 7, lfsr_data[0] + 32'd5);
    add_store("load_use_store", 8, lfsr_data[6]);
    add_store("bne_taken", 9, 32'hffff_fffb);
    add_store("blt_taken", 10, 32'h0000_0003);
    add_store("jump", 11, 32'h0000_1200);
    add_store("bne_not_taken", 12, 32'h0000_0003);
    add_store("blt_not_taken", 13, 32'hffff_fffb);
    add_store("final_store", 63, lfsr_data[0] + 32'd5);
endtask

`endif

// File: verif/cpu_tb.sv
// ========================================
// cpu testbench
// memory models, LFSR data and store checks
// for the five-stage pipeline
// ========================================
`timescale 1ns/100ps

module cpu_tb import cpu_pkg::*; ();

    localparam int          PC_W        = 8;
    localparam int          DADDR_W     = 8;
    localparam int          IMEM_WORDS  = 1 << PC_W;
    localparam int          DMEM_WORDS  = 1 << DADDR_W;
    localparam int          MAX_STORES  = 32;
    localparam int          POISON_ADDR = 60;
    localparam logic [31:0] LFSR_SEED   = 32'h33fe3600;
    localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

    typedef struct packed {
        logic [DADDR_W-1:0] addr;
        logic [XLEN-1:0]    data;
    } store_t;

    logic               clk;
    logic               rst_n;
    logic [PC_W-1:0]    imem_addr;
    logic [XLEN-1:0]    imem_data;
    logic [DADDR_W-1:0] dmem_addr;
    logic [XLEN-1:0]    dmem_wdata;
    logic               dmem_we;
    logic [XLEN-1:0]    dmem_rdata;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [XLEN-1:0] lfsr_data [8];            // words 32 to 39
    logic [31:0]     lfsr_state = LFSR_SEED;
    store_t          exp_store [MAX_STORES];
    string           exp_name [MAX_STORES];
    int              n_exp = 0;
    int              store_idx = 0;
    int              cycle_cnt = 0;
    int              post_rst_cyc = 0;
    int              halt_seen;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string test, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        abort_run($sformatf("FAIL %s: expected %h, actual %h", test, expected, actual));
    endtask

    task automatic add_store(input string name, input int st_addr, input logic [XLEN-1:0] st_data);
        exp_name[n_exp]       = name;
        exp_store[n_exp].addr = DADDR_W'(st_addr);
        exp_store[n_exp].data = st_data;
        n_exp++;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    `include "cpu_tb_prog.svh"

    // instructions, 3 taken x 2, 2 load-use, fill 4, reset 2, halt loop 4
    localparam int TIMEOUT_CYCLES = 5 * (PROG_LEN + 6 + 2 + 4 + 2 + 4);

    task automatic fill_dmem();
        for (int w = 0; w < 8; w++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr_state      = lfsr_next(lfsr_state);
                lfsr_data[w][b] = lfsr_state[0];       // one step per bit
            end
        end
        for (int a = 0; a < DMEM_WORDS; a++) begin
            dmem[a] <= {a[7:0], ~a[7:0], a[7:0], ~a[7:0]};
        end
        for (int w = 0; w < 8; w++) begin
            dmem[32 + w] <= lfsr_data[w];
        end
    endtask

    cpu_top #(.PC_W(PC_W), .DADDR_W(DADDR_W)) uut (
        .clk(clk), .rst_n_i(rst_n), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_we_o(dmem_we),
        .dmem_rdata_i(dmem_rdata)
    );

    assign imem_data  = imem[imem_addr];       // combinational reads
    assign dmem_rdata = dmem[dmem_addr];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
            store_idx       <= store_idx + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: no final jump loop after %0d cycles", cycle_cnt));
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            post_rst_cyc <= 0;
        end else begin
            post_rst_cyc <= post_rst_cyc + 1;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        (!rst_n || post_rst_cyc == 0) |-> !dmem_we)
        else abort_run("data memory write strobe high during or right after reset");

    a_no_poison: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> (dmem_addr != DADDR_W'(POISON_ADDR)))
        else abort_run("store to the poison address, a flushed instruction reached memory");

    a_store_in_list: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> (store_idx < n_exp))
        else abort_run("store after the last expected store");

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_we && store_idx < n_exp) |-> (dmem_addr == exp_store[store_idx].addr))
        else report_mismatch({exp_name[$sampled(store_idx)], " addr"},
                             XLEN'(exp_store[$sampled(store_idx)].addr),
                             XLEN'($sampled(dmem_addr)));

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_we && store_idx < n_exp) |-> (dmem_wdata == exp_store[store_idx].data))
        else report_mismatch(exp_name[$sampled(store_idx)],
                             exp_store[$sampled(store_idx)].data, $sampled(dmem_wdata));

    initial begin
        rst_n = 1'b0;
        load_program();
        fill_dmem();
        build_expected();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        wait (store_idx == n_exp);              // last store goes to 63
        halt_seen = 0;
        while (halt_seen < 2) begin
            @(negedge clk);
            if (imem_addr == PC_W'(HALT_PC)) begin
                halt_seen++;                    // j keeps coming back
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verif
logic/cpu_pkg.sv
logic/reg_file.sv
logic/hazard_ctrl.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/cpu_top.sv
verif/cpu_tb.sv

// File: run.sh
#!/bin/sh
# build the cpu testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert --top-module cpu_tb -f vlog.f -o cpu_sim &&
    ./obj_dir/cpu_sim | tee /dev/stderr | grep -q "TEST OK" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
